/* bench/tb_soc_platform.sv */
// Host-side testbench for the platform with a RAM model on the memory port
// rtc pulses last several aclk cycles so the synchronizer sees every edge
`timescale 1ns/100ps
`default_nettype none

`include "platform_settings.svh"

module tb_soc_platform;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 6;

    logic                  aclk;
    logic                  reset;
    logic                  host_req;
    bus_pkg::bus_cmd_t     host_cmd;
    logic                  rsp_ack;
    logic                  mem_ack;
    logic [`PLAT_XLEN-1:0] mem_rdata;
    logic                  rtc;
    logic [`PLAT_XLEN-1:0] gpio_in;
    logic                  host_ack;
    logic                  rsp_req;
    bus_pkg::bus_rsp_t     rsp_data;
    logic                  mem_req;
    bus_pkg::bus_cmd_t     mem_cmd;
    logic [`PLAT_XLEN-1:0] gpio_out;
    logic                  timer_irq;

    int    seed = 32'h6e9;
    int    errors;
    int    test_errors;
    int    tests_failed;
    int    mem_count;
    string test_name;

    // Words the tests wrote to RAM
    logic [`PLAT_XLEN-1:0] written [logic [`PLAT_ADDR_W-1:0]];
    // Contents of the RAM model
    logic [`PLAT_XLEN-1:0] ram_store [logic [`PLAT_ADDR_W-1:0]];

    soc_platform dut0 (
        .aclk      (aclk),
        .reset     (reset),
        .host_req  (host_req),
        .host_cmd  (host_cmd),
        .rsp_ack   (rsp_ack),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .rtc       (rtc),
        .gpio_in   (gpio_in),
        .host_ack  (host_ack),
        .rsp_req   (rsp_req),
        .rsp_data  (rsp_data),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .gpio_out  (gpio_out),
        .timer_irq (timer_irq)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    //////////////////////////////
    // Checks
    //////////////////////////////
    task automatic report_failure(input string msg);
        $display("%0s: %0s", test_name, msg);
        errors++;
        test_errors++;
    endtask

    task automatic expect_word(input string what, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("MISMATCH %0s %0s: expected %h, actual %h", test_name, what, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    assert property (@(posedge aclk) disable iff (reset) $rose(host_ack) |-> $past(host_req))
        else report_failure("host_ack rose while host_req was low");

    assert property (@(posedge aclk) disable iff (reset)
                     (rsp_req && $past(rsp_req)) |-> $stable(rsp_data))
        else report_failure("rsp_data changed while rsp_req was high");

    assert property (@(posedge aclk) disable iff (reset) $fell(mem_req) |-> $past(mem_ack))
        else report_failure("mem_req dropped before mem_ack");

    assert property (@(posedge aclk) disable iff (reset)
                     mem_req |-> (mem_cmd.addr <= `PLAT_RAM_END))
        else report_failure("memory port carried an address outside RAM");

    //////////////////////////////
    // Host side helpers
    //////////////////////////////
    task automatic next_edge();
        @(posedge aclk);
        #2;
    endtask

    function automatic logic [31:0] pattern_word(input logic [`PLAT_ADDR_W-1:0] addr);
        return {{(32 - `PLAT_ADDR_W){1'b0}}, addr} ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] expected_ram(input logic [`PLAT_ADDR_W-1:0] addr);
        return written.exists(addr) ? written[addr] : pattern_word(addr);
    endfunction

    task automatic send_cmd(input logic [`PLAT_ADDR_W-1:0] addr, input logic we,
                            input logic [31:0] wdata);
        host_cmd.addr  = addr;
        host_cmd.we    = we;
        host_cmd.wdata = wdata;
        host_req       = 1'b1;
        do begin
            next_edge();
        end while (!host_ack);
        host_req = 1'b0;
        do begin
            next_edge();
        end while (host_ack);
    endtask

    task automatic write_word(input logic [`PLAT_ADDR_W-1:0] addr, input logic [31:0] data);
        if (addr <= `PLAT_RAM_END) begin
            written[addr] = data;
        end
        send_cmd(addr, 1'b1, data);
    endtask

    task automatic take_rsp(output bus_pkg::bus_rsp_t rsp);
        while (!rsp_req) begin
            next_edge();
        end
        rsp     = rsp_data;
        rsp_ack = 1'b1;
        do begin
            next_edge();
        end while (rsp_req);
        rsp_ack = 1'b0;
    endtask

    task automatic read_word(input logic [`PLAT_ADDR_W-1:0] addr, output bus_pkg::bus_rsp_t rsp);
        send_cmd(addr, 1'b0, '0);
        take_rsp(rsp);
    endtask

    task automatic pulse_rtc();
        rtc = 1'b1;
        repeat (3) next_edge();
        rtc = 1'b0;
        repeat (3) next_edge();
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %0s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %0s failed with %0d errors", test_name, test_errors);
        end
    endtask

    //////////////////////////////
    // RAM model
    //////////////////////////////
    initial begin : ram_model
        int unsigned             delay;
        logic [`PLAT_ADDR_W-1:0] addr;
        forever begin
            next_edge();
            if (mem_req && !mem_ack) begin
                delay = $unsigned($random(seed)) % 4;
                addr  = mem_cmd.addr;
                mem_count++;
                repeat (delay) next_edge();
                if (mem_cmd.we) begin
                    ram_store[addr] = mem_cmd.wdata;
                end
                mem_rdata = ram_store.exists(addr) ? ram_store[addr] : pattern_word(addr);
                mem_ack   = 1'b1;
                do begin
                    next_edge();
                end while (mem_req);
                mem_ack = 1'b0;
            end
        end
    end

    //////////////////////////////
    // Tests
    //////////////////////////////
    initial begin : stimulus
        bus_pkg::bus_rsp_t rsp;
        int                accesses;
        reset        = 1'b1;
        host_req     = 1'b0;
        host_cmd     = '0;
        rsp_ack      = 1'b0;
        mem_ack      = 1'b0;
        mem_rdata    = '0;
        rtc          = 1'b0;
        gpio_in      = '0;
        errors       = 0;
        test_errors  = 0;
        tests_failed = 0;
        mem_count    = 0;
        test_name    = "reset";
        repeat (4) @(posedge aclk);
        #2;
        reset = 1'b0;

        start_test("reset_state");
        expect_word("ack/req/irq", 32'h0, {28'h0, host_ack, rsp_req, mem_req, timer_irq});
        expect_word("gpio_out", 32'h0, gpio_out);
        read_word(`PLAT_IO_BASE + `PLAT_MTIME_OFS, rsp);
        expect_word("mtime", 32'h0, rsp.rdata);
        finish_test();

        start_test("gpio");
        gpio_in = 32'hc0ffee15;
        write_word(`PLAT_IO_BASE + `PLAT_GPIO_OUT_OFS, 32'ha5c30f96);
        read_word(`PLAT_IO_BASE + `PLAT_GPIO_OUT_OFS, rsp);
        expect_word("gpio_out read", 32'ha5c30f96, rsp.rdata);
        expect_word("gpio_out pin", 32'ha5c30f96, gpio_out);
        read_word(`PLAT_IO_BASE + `PLAT_GPIO_IN_OFS, rsp);
        expect_word("gpio_in read", 32'hc0ffee15, rsp.rdata);
        finish_test();

        start_test("ram");
        read_word(24'h000040, rsp);
        expect_word("unwritten rdata", expected_ram(24'h000040), rsp.rdata);
        expect_word("unwritten err", 32'h0, rsp.err);
        write_word(24'h000080, 32'hdeadbeef);
        read_word(24'h000080, rsp);
        expect_word("written rdata", expected_ram(24'h000080), rsp.rdata);
        expect_word("written err", 32'h0, rsp.err);
        finish_test();

        start_test("timer");
        write_word(`PLAT_IO_BASE + `PLAT_MTIMECMP_OFS, 32'd3);
        read_word(`PLAT_IO_BASE + `PLAT_MTIMECMP_OFS, rsp);
        expect_word("mtimecmp", 32'd3, rsp.rdata);
        for (int i = 1; i <= 3; i++) begin
            pulse_rtc();
            expect_word("timer_irq", (i >= 3) ? 32'd1 : 32'd0, timer_irq);
        end
        read_word(`PLAT_IO_BASE + `PLAT_MTIME_OFS, rsp);
        expect_word("mtime", 32'd3, rsp.rdata);
        expect_word("timer_irq held", 32'd1, timer_irq);
        finish_test();

        start_test("unmapped");
        accesses = mem_count;
        read_word(24'h200000, rsp);
        expect_word("region rdata", 32'h0, rsp.rdata);
        expect_word("region err", 32'h1, rsp.err);
        read_word(`PLAT_IO_BASE + 24'h000040, rsp);
        expect_word("io offset rdata", 32'h0, rsp.rdata);
        expect_word("io offset err", 32'h1, rsp.err);
        expect_word("memory accesses", accesses, mem_count);
        finish_test();

        // Six reads queued while rsp_ack stays low
        start_test("backpressure");
        write_word(24'h000208, 32'h0badf00d);
        for (int i = 0; i < 6; i++) begin
            send_cmd(24'h000200 + 24'(4 * i), 1'b0, '0);
        end
        for (int i = 0; i < 6; i++) begin
            take_rsp(rsp);
            expect_word("ordered rdata", expected_ram(24'h000200 + 24'(4 * i)), rsp.rdata);
            expect_word("ordered err", 32'h0, rsp.err);
        end
        finish_test();

        $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish", NUM_TESTS * 200);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* design/bus_pkg.sv */
// Transaction payloads carried between the host, the queues and the engine
// Every access is a full word, no byte strobes
`default_nettype none

`include "platform_settings.svh"

package bus_pkg;

    // One host request, 57 bits
    typedef struct packed {
        logic [`PLAT_ADDR_W-1:0] addr;
        logic                    we;
        logic [`PLAT_XLEN-1:0]   wdata;
    } bus_cmd_t;

    // One read result, 33 bits
    // err flags an unmapped address or IO offset
    typedef struct packed {
        logic [`PLAT_XLEN-1:0] rdata;
        logic                  err;
    } bus_rsp_t;

endpackage

`default_nettype wire

/* design/cmd_queue.sv */
// Synchronous FIFO of PLAT_QUEUE_DEPTH entries, any packed payload
// A push while full or a pop while empty is ignored
`timescale 1ns/100ps
`default_nettype none

`include "platform_settings.svh"

module cmd_queue #(
    parameter type item_t = logic [7:0]
) (
    input  wire        aclk,
    input  wire        reset,
    input  wire        push,
    input  wire item_t push_item,
    input  wire        pop,
    output item_t      head_item,
    output logic       full,
    output logic       empty
);

    localparam int DEPTH = `PLAT_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full      = (count == CNT_W'(DEPTH));
    assign empty     = (count == '0);
    assign head_item = mem[rd_ptr];

    // Storage
    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/host_port.sv */
// Host side handshakes, both four-phase
// Only one request is open at a time; the next is taken after host_ack drops
`timescale 1ns/100ps
`default_nettype none

module host_port (
    input  wire               aclk,
    input  wire               reset,
    input  wire               host_req,
    input  wire bus_pkg::bus_cmd_t host_cmd,
    input  wire               rsp_ack,
    input  wire               cmd_full,
    input  wire               rsp_empty,
    input  wire bus_pkg::bus_rsp_t rsp_head,
    output logic              host_ack,
    output logic              rsp_req,
    output bus_pkg::bus_rsp_t rsp_data,
    output logic              cmd_push,
    output bus_pkg::bus_cmd_t cmd_item,
    output logic              rsp_pop
);

    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_PUSHED,
        REQ_ACKED
    } req_state_t;

    typedef enum logic [1:0] {
        RSP_IDLE,
        RSP_OFFER,
        RSP_DRAIN
    } rsp_state_t;

    req_state_t req_state;
    rsp_state_t rsp_state;

    //////////////////////////////
    // Request channel
    //////////////////////////////

    // Push on the first edge that sees the request with room in the queue
    assign cmd_push = (req_state == REQ_IDLE) && host_req && !cmd_full;
    assign cmd_item = host_cmd;

    always_ff @(posedge aclk) begin
        if (reset) begin
            req_state <= REQ_IDLE;
            host_ack  <= 1'b0;
        end else begin
            case (req_state)
                REQ_IDLE: begin
                    if (cmd_push) begin
                        req_state <= REQ_PUSHED;
                    end
                end
                REQ_PUSHED: begin
                    host_ack  <= 1'b1;
                    req_state <= REQ_ACKED;
                end
                default: begin
                    // Wait for the host to release its request
                    if (!host_req) begin
                        host_ack  <= 1'b0;
                        req_state <= REQ_IDLE;
                    end
                end
            endcase
        end
    end

    //////////////////////////////
    // Response channel
    //////////////////////////////

    // Head stays put until the pop, so the data is stable under rsp_req
    assign rsp_data = rsp_head;
    assign rsp_pop  = (rsp_state == RSP_OFFER) && rsp_ack;

    always_ff @(posedge aclk) begin
        if (reset) begin
            rsp_state <= RSP_IDLE;
            rsp_req   <= 1'b0;
        end else begin
            case (rsp_state)
                RSP_IDLE: begin
                    if (!rsp_empty) begin
                        rsp_req   <= 1'b1;
                        rsp_state <= RSP_OFFER;
                    end
                end
                RSP_OFFER: begin
                    if (rsp_ack) begin
                        rsp_req   <= 1'b0;
                        rsp_state <= RSP_DRAIN;
                    end
                end
                default: begin
                    if (!rsp_ack) begin
                        rsp_state <= RSP_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/io_regs.sv */
// GPIO registers and a 32-bit CLINT-style timer clocked by rtc edges
// rtc must be slower than aclk by at least a factor of two
`timescale 1ns/100ps
`default_nettype none

`include "platform_settings.svh"

module io_regs (
    input  wire                       aclk,
    input  wire                       reset,
    input  wire                       rtc,
    input  wire memmap_pkg::io_reg_t  sel,
    input  wire                       wr,
    input  wire  [`PLAT_XLEN-1:0]     wdata,
    input  wire  [`PLAT_XLEN-1:0]     gpio_in,
    output logic [`PLAT_XLEN-1:0]     rdata,
    output logic [`PLAT_XLEN-1:0]     gpio_out,
    output logic                      timer_irq
);

    logic                  rtc_meta;
    logic                  rtc_sync;
    logic                  rtc_prev;
    logic                  rtc_rise;
    logic                  cmp_init;
    logic [`PLAT_XLEN-1:0] gpio_in_q;
    logic [`PLAT_XLEN-1:0] mtime;
    logic [`PLAT_XLEN-1:0] mtimecmp;

    //////////////////////////////
    // rtc synchronizer
    //////////////////////////////
    always_ff @(posedge aclk) begin
        if (reset) begin
            rtc_meta <= 1'b0;
            rtc_sync <= 1'b0;
            rtc_prev <= 1'b0;
        end else begin
            rtc_meta <= rtc;
            rtc_sync <= rtc_meta;
            rtc_prev <= rtc_sync;
        end
    end

    assign rtc_rise = rtc_sync && !rtc_prev;

    // Input port sample
    always_ff @(posedge aclk) begin
        gpio_in_q <= gpio_in;
    end

    //////////////////////////////
    // Registers and timer
    //////////////////////////////
    always_ff @(posedge aclk) begin
        if (reset) begin
            gpio_out  <= '0;
            mtime     <= '0;
            mtimecmp  <= '0;
            cmp_init  <= 1'b1;
            timer_irq <= 1'b0;
        end else begin
            cmp_init <= 1'b0;
            // Compare value parks at all ones after reset, irq off
            if (cmp_init) begin
                mtimecmp <= '1;
            end
            if (wr && sel == memmap_pkg::MTIMECMP) begin
                mtimecmp <= wdata;
            end
            if (wr && sel == memmap_pkg::GPIO_OUT) begin
                gpio_out <= wdata;
            end
            if (wr && sel == memmap_pkg::MTIME) begin
                mtime <= wdata;
            end else if (rtc_rise) begin
                mtime <= mtime + 1'b1;
            end
            timer_irq <= !cmp_init && (mtime >= mtimecmp);
        end
    end

    // Read mux, BAD reads as zero
    always_comb begin
        case (sel)
            memmap_pkg::GPIO_OUT: rdata = gpio_out;
            memmap_pkg::GPIO_IN:  rdata = gpio_in_q;
            memmap_pkg::MTIME:    rdata = mtime;
            memmap_pkg::MTIMECMP: rdata = mtimecmp;
            default:              rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/memmap_pkg.sv */
// Decode targets of the platform memory map
`default_nettype none

package memmap_pkg;

    //////////////////////////////
    // Address regions
    //////////////////////////////
    typedef enum logic [1:0] {
        RAM  = 2'd0,
        IO   = 2'd1,
        NONE = 2'd2
    } region_t;

    //////////////////////////////
    // IO registers
    //////////////////////////////

    // BAD covers every offset without a register behind it
    typedef enum logic [2:0] {
        GPIO_OUT = 3'd0,
        GPIO_IN  = 3'd1,
        MTIME    = 3'd2,
        MTIMECMP = 3'd3,
        BAD      = 3'd4
    } io_reg_t;

endpackage

`default_nettype wire

/* design/platform_settings.svh */
// Widths, queue depth and memory map of the platform
// IO offsets are relative to PLAT_IO_BASE and must be word aligned
`ifndef PLATFORM_SETTINGS_SVH
`define PLATFORM_SETTINGS_SVH

// Datapath
`define PLAT_XLEN           32
`define PLAT_ADDR_W         24

// Entries in the command and response queues
`define PLAT_QUEUE_DEPTH    4

//////////////////////////////
// Memory map
//////////////////////////////
`define PLAT_RAM_END        24'h0F_FFFF
`define PLAT_IO_BASE        24'h10_0000

`define PLAT_GPIO_OUT_OFS   24'h00_0000
`define PLAT_GPIO_IN_OFS    24'h00_0004
`define PLAT_MTIME_OFS      24'h00_0018
`define PLAT_MTIMECMP_OFS   24'h00_001C

`endif

/* design/soc_platform.sv */
// Platform top, one host requester with in-order read responses
// RAM sits outside behind the four-phase memory port
`timescale 1ns/100ps
`default_nettype none

`include "platform_settings.svh"

module soc_platform (
    input  wire                    aclk,
    input  wire                    reset,
    input  wire                    host_req,
    input  wire bus_pkg::bus_cmd_t host_cmd,
    input  wire                    rsp_ack,
    input  wire                    mem_ack,
    input  wire  [`PLAT_XLEN-1:0]  mem_rdata,
    input  wire                    rtc,
    input  wire  [`PLAT_XLEN-1:0]  gpio_in,
    output logic                   host_ack,
    output logic                   rsp_req,
    output bus_pkg::bus_rsp_t      rsp_data,
    output logic                   mem_req,
    output bus_pkg::bus_cmd_t      mem_cmd,
    output logic [`PLAT_XLEN-1:0]  gpio_out,
    output logic                   timer_irq
);

    // Command path
    logic                  cmd_push;
    bus_pkg::bus_cmd_t     cmd_item;
    logic                  cmd_full;
    logic                  cmd_pop;
    bus_pkg::bus_cmd_t     cmd_head;
    logic                  cmd_empty;

    // Response path
    logic                  rsp_push;
    bus_pkg::bus_rsp_t     rsp_item;
    logic                  rsp_full;
    logic                  rsp_pop;
    bus_pkg::bus_rsp_t     rsp_head;
    logic                  rsp_empty;

    // IO register access
    memmap_pkg::io_reg_t   io_sel;
    logic                  io_wr;
    logic [`PLAT_XLEN-1:0] io_wdata;
    logic [`PLAT_XLEN-1:0] io_rdata;

    //////////////////////////////
    // Instances
    //////////////////////////////
    host_port port0 (
        .aclk      (aclk),
        .reset     (reset),
        .host_req  (host_req),
        .host_cmd  (host_cmd),
        .rsp_ack   (rsp_ack),
        .cmd_full  (cmd_full),
        .rsp_empty (rsp_empty),
        .rsp_head  (rsp_head),
        .host_ack  (host_ack),
        .rsp_req   (rsp_req),
        .rsp_data  (rsp_data),
        .cmd_push  (cmd_push),
        .cmd_item  (cmd_item),
        .rsp_pop   (rsp_pop)
    );

    cmd_queue #(.item_t(bus_pkg::bus_cmd_t)) cmd_q0 (
        .aclk      (aclk),
        .reset     (reset),
        .push      (cmd_push),
        .push_item (cmd_item),
        .pop       (cmd_pop),
        .head_item (cmd_head),
        .full      (cmd_full),
        .empty     (cmd_empty)
    );

    cmd_queue #(.item_t(bus_pkg::bus_rsp_t)) rsp_q0 (
        .aclk      (aclk),
        .reset     (reset),
        .push      (rsp_push),
        .push_item (rsp_item),
        .pop       (rsp_pop),
        .head_item (rsp_head),
        .full      (rsp_full),
        .empty     (rsp_empty)
    );

    txn_engine engine0 (
        .aclk      (aclk),
        .reset     (reset),
        .cmd_empty (cmd_empty),
        .cmd_head  (cmd_head),
        .rsp_full  (rsp_full),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .io_rdata  (io_rdata),
        .cmd_pop   (cmd_pop),
        .rsp_push  (rsp_push),
        .rsp_item  (rsp_item),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .io_sel    (io_sel),
        .io_wr     (io_wr),
        .io_wdata  (io_wdata)
    );

    io_regs io0 (
        .aclk      (aclk),
        .reset     (reset),
        .rtc       (rtc),
        .sel       (io_sel),
        .wr        (io_wr),
        .wdata     (io_wdata),
        .gpio_in   (gpio_in),
        .rdata     (io_rdata),
        .gpio_out  (gpio_out),
        .timer_irq (timer_irq)
    );

endmodule

`default_nettype wire

/* design/txn_engine.sv */
// Executes queued commands in order against RAM or the IO registers
// Writes are posted; only reads produce a response
`timescale 1ns/100ps
`default_nettype none

`include "platform_settings.svh"

module txn_engine (
    input  wire                        aclk,
    input  wire                        reset,
    input  wire                        cmd_empty,
    input  wire bus_pkg::bus_cmd_t     cmd_head,
    input  wire                        rsp_full,
    input  wire                        mem_ack,
    input  wire  [`PLAT_XLEN-1:0]      mem_rdata,
    input  wire  [`PLAT_XLEN-1:0]      io_rdata,
    output logic                       cmd_pop,
    output logic                       rsp_push,
    output bus_pkg::bus_rsp_t          rsp_item,
    output logic                       mem_req,
    output bus_pkg::bus_cmd_t          mem_cmd,
    output memmap_pkg::io_reg_t        io_sel,
    output logic                       io_wr,
    output logic [`PLAT_XLEN-1:0]      io_wdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MEM,
        ST_HOLD
    } state_t;

    state_t                  state;
    memmap_pkg::region_t     region;
    logic [`PLAT_ADDR_W-1:0] io_ofs;
    logic                    take;
    bus_pkg::bus_rsp_t       mem_rsp;
    bus_pkg::bus_rsp_t       rsp_hold;

    //////////////////////////////
    // Address decode
    //////////////////////////////
    assign io_ofs = cmd_head.addr - `PLAT_IO_BASE;

    always_comb begin
        // IO window is 1 MB, the same span as RAM
        if (cmd_head.addr <= `PLAT_RAM_END) begin
            region = memmap_pkg::RAM;
        end else if (cmd_head.addr >= `PLAT_IO_BASE && io_ofs <= `PLAT_RAM_END) begin
            region = memmap_pkg::IO;
        end else begin
            region = memmap_pkg::NONE;
        end
        case (io_ofs)
            `PLAT_GPIO_OUT_OFS: io_sel = memmap_pkg::GPIO_OUT;
            `PLAT_GPIO_IN_OFS:  io_sel = memmap_pkg::GPIO_IN;
            `PLAT_MTIME_OFS:    io_sel = memmap_pkg::MTIME;
            `PLAT_MTIMECMP_OFS: io_sel = memmap_pkg::MTIMECMP;
            default:            io_sel = memmap_pkg::BAD;
        endcase
    end

    // A new RAM access waits until the previous ack is gone
    assign take    = (state == ST_IDLE) && !cmd_empty
                     && !(region == memmap_pkg::RAM && mem_ack);
    assign cmd_pop = take;

    // IO accesses happen in the pop cycle
    assign io_wr    = take && (region == memmap_pkg::IO) && cmd_head.we;
    assign io_wdata = cmd_head.wdata;

    //////////////////////////////
    // Response path
    //////////////////////////////
    assign mem_rsp.rdata = mem_rdata;
    assign mem_rsp.err   = 1'b0;

    assign rsp_item = (state == ST_MEM) ? mem_rsp : rsp_hold;
    assign rsp_push = !rsp_full
                      && ((state == ST_HOLD)
                          || (state == ST_MEM && mem_ack && !mem_cmd.we));

    always_ff @(posedge aclk) begin
        if (reset) begin
            state   <= ST_IDLE;
            mem_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take && region == memmap_pkg::RAM) begin
                        mem_req <= 1'b1;
                        state   <= ST_MEM;
                    end else if (take && !cmd_head.we) begin
                        state <= ST_HOLD;
                    end
                end
                ST_MEM: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        // Read with a full response queue parks in HOLD
                        state <= (!mem_cmd.we && rsp_full) ? ST_HOLD : ST_IDLE;
                    end
                end
                default: begin
                    if (!rsp_full) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge aclk) begin
        if (take && region == memmap_pkg::RAM) begin
            mem_cmd <= cmd_head;
        end
        if (take && region == memmap_pkg::IO) begin
            rsp_hold.rdata <= io_rdata;
            rsp_hold.err   <= (io_sel == memmap_pkg::BAD);
        end else if (take && region == memmap_pkg::NONE) begin
            rsp_hold.rdata <= '0;
            rsp_hold.err   <= 1'b1;
        end else if (state == ST_MEM && mem_ack) begin
            rsp_hold <= mem_rsp;
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+design
design/bus_pkg.sv
design/memmap_pkg.sv
design/host_port.sv
design/cmd_queue.sv
design/io_regs.sv
design/txn_engine.sv
design/soc_platform.sv
bench/tb_soc_platform.sv
